// File: uram_cfg_pkg.sv
//################################################
// Geometry and latency of the shared table memory
// Word width is always NUM_COL full byte columns
// RD_LAT counts from the accepting cycle to rvalid
//################################################

package uram_cfg_pkg;

  // Address space
  localparam int ADDR_W = 12;
  localparam int DEPTH  = 1 << ADDR_W;       // Full power-of-two table

  // Byte columns
  localparam int NUM_COL = 9;
  localparam int COL_W   = 8;
  localparam int DATA_W  = NUM_COL * COL_W;  // Always whole columns

  // Output side
  localparam int NBPIPE = 3;                 // Data pipeline stages
  localparam int RD_LAT = NBPIPE + 2;        // Array read and output register on top

  // Post-reset zero sweep, one word per cycle
  localparam int CLEAR_CYCLES = DEPTH;

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [NUM_COL-1:0] wmask_t;       // One bit per byte column

endpackage

// File: uram_arb_pkg.sv
//################################################
// Client set sharing memory port A
// Grant logic is written for exactly two clients
//################################################

package uram_arb_pkg;

  localparam int NUM_CLIENTS = 2;
  localparam int CID_W       = $clog2(NUM_CLIENTS);

  typedef logic [CID_W-1:0] cid_t;

  // Client ids as carried with each read
  localparam cid_t CID_C0 = cid_t'(0);
  localparam cid_t CID_C1 = cid_t'(1);

  // Winner assumed at reset so client 0 takes the first tie
  localparam cid_t CID_RST_LAST = CID_C1;

endpackage

// File: uram_tdp_bytewrite.sv
//################################################
// True dual-port table, byte-column writes
// No-change reads: write cycles leave rdata as is
// Same-address writes from both ports collide
// undefined, caller must avoid them
//################################################
`timescale 1ns/100ps

module uram_tdp_bytewrite (
  input  logic                 clk,
  input  logic                 rsta,

  // Port A
  input  logic                 i_a_en,
  input  uram_cfg_pkg::wmask_t i_a_wmask,
  input  uram_cfg_pkg::addr_t  i_a_addr,
  input  uram_cfg_pkg::data_t  i_a_wdata,

  // Port B
  input  logic                 i_b_en,
  input  uram_cfg_pkg::wmask_t i_b_wmask,
  input  uram_cfg_pkg::addr_t  i_b_addr,
  input  uram_cfg_pkg::data_t  i_b_wdata,

  output uram_cfg_pkg::data_t  o_a_rdata,
  output logic                 o_a_rvalid,
  output uram_cfg_pkg::data_t  o_b_rdata,
  output logic                 o_b_rvalid
);

  // Storage, no reset
  uram_cfg_pkg::data_t mem [uram_cfg_pkg::DEPTH];

  // Ports gathered as index 0 = A, 1 = B
  logic                 en     [2];
  uram_cfg_pkg::wmask_t wmask  [2];
  uram_cfg_pkg::addr_t  addr   [2];
  uram_cfg_pkg::data_t  wdata  [2];
  uram_cfg_pkg::data_t  rdata  [2];
  logic                 rvalid [2];

  assign en[0]    = i_a_en;
  assign wmask[0] = i_a_wmask;
  assign addr[0]  = i_a_addr;
  assign wdata[0] = i_a_wdata;
  assign en[1]    = i_b_en;
  assign wmask[1] = i_b_wmask;
  assign addr[1]  = i_b_addr;
  assign wdata[1] = i_b_wdata;

  assign o_a_rdata  = rdata[0];
  assign o_a_rvalid = rvalid[0];
  assign o_b_rdata  = rdata[1];
  assign o_b_rvalid = rvalid[1];

  // Column writes, both ports, one edge
  always_ff @(posedge clk)
  begin
    for (int p = 0; p < 2; p++)
    begin
      if (en[p])
      begin
        for (int c = 0; c < uram_cfg_pkg::NUM_COL; c++)
        begin
          if (wmask[p][c])
            mem[addr[p]][c*uram_cfg_pkg::COL_W +: uram_cfg_pkg::COL_W] <=
              wdata[p][c*uram_cfg_pkg::COL_W +: uram_cfg_pkg::COL_W];
        end
      end
    end
  end

  // Read path per port
  for (genvar p = 0; p < 2; p++)
  begin : g_port
    logic                            rd;           // Enabled, no column written
    uram_cfg_pkg::data_t             mem_q;        // Array output latch
    uram_cfg_pkg::data_t             pipe_q [uram_cfg_pkg::NBPIPE];
    logic [uram_cfg_pkg::NBPIPE:0]   rd_sr;        // Read marker per stage
    uram_cfg_pkg::data_t             rdata_q;
    logic                            rvalid_q;

    assign rd = en[p] & ~|wmask[p];

    // Data stages advance only behind a read
    always_ff @(posedge clk)
    begin
      if (rd)
        mem_q <= mem[addr[p]];
      if (rd_sr[0])
        pipe_q[0] <= mem_q;
      for (int s = 1; s < uram_cfg_pkg::NBPIPE; s++)
      begin
        if (rd_sr[s])
          pipe_q[s] <= pipe_q[s-1];
      end
    end

    // Marker shift and the clearable output stage
    always_ff @(posedge clk)
    begin
      if (rsta)
      begin
        rd_sr    <= '0;
        rdata_q  <= '0;
        rvalid_q <= 1'b0;
      end
      else
      begin
        rd_sr    <= {rd_sr[uram_cfg_pkg::NBPIPE-1:0], rd};
        rvalid_q <= rd_sr[uram_cfg_pkg::NBPIPE];  // Lines up with rdata load
        if (rd_sr[uram_cfg_pkg::NBPIPE])
          rdata_q <= pipe_q[uram_cfg_pkg::NBPIPE-1];
      end
    end

    assign rdata[p]  = rdata_q;
    assign rvalid[p] = rvalid_q;
  end

endmodule

// File: uram_clear_seq.sv
//################################################
// Zero sweep of every word after reset
// Owns port A until done, then passes it through
// One idle handover cycle before done rises
//################################################
`timescale 1ns/100ps

module uram_clear_seq (
  input  logic                 clk,
  input  logic                 rsta,

  // From the arbiter
  input  logic                 i_en,
  input  uram_cfg_pkg::wmask_t i_wmask,
  input  uram_cfg_pkg::addr_t  i_addr,
  input  uram_cfg_pkg::data_t  i_wdata,

  // To memory port A
  output logic                 o_en,
  output uram_cfg_pkg::wmask_t o_wmask,
  output uram_cfg_pkg::addr_t  o_addr,
  output uram_cfg_pkg::data_t  o_wdata,

  output logic                 o_clear_done
);

  logic [uram_cfg_pkg::ADDR_W:0] cnt;  // Top bit set once every word is written
  logic                          sweep;

  assign sweep = (cnt < uram_cfg_pkg::CLEAR_CYCLES);

  always_ff @(posedge clk)
  begin
    if (rsta)
    begin
      cnt          <= '0;
      o_clear_done <= 1'b0;
    end
    else
    begin
      if (sweep)
        cnt <= cnt + 1'b1;     // Parks past the last word
      if (!sweep)
        o_clear_done <= 1'b1;  // Sticky
    end
  end

  // Port A mux
  always_comb
  begin
    if (sweep)
    begin
      o_en    = 1'b1;
      o_wmask = '1;                                   // All columns
      o_addr  = cnt[uram_cfg_pkg::ADDR_W-1:0];
      o_wdata = '0;
    end
    else
    begin
      o_en    = i_en;   // Arbiter is idle until done anyway
      o_wmask = i_wmask;
      o_addr  = i_addr;
      o_wdata = i_wdata;
    end
  end

endmodule

// File: uram_port_arb.sv
//################################################
// Round-robin share of port A by two clients
// Requests are held levels, grant is same-cycle
// Read data cannot be stalled, no back-pressure
//################################################
`timescale 1ns/100ps

module uram_port_arb (
  input  logic                 clk,
  input  logic                 rsta,
  input  logic                 i_clear_done,

  // Client 0
  input  logic                 i_c0_req,
  input  uram_cfg_pkg::wmask_t i_c0_wmask,   // Zero mask is a read
  input  uram_cfg_pkg::addr_t  i_c0_addr,
  input  uram_cfg_pkg::data_t  i_c0_wdata,
  output logic                 o_c0_gnt,
  output logic                 o_c0_rvalid,
  output uram_cfg_pkg::data_t  o_c0_rdata,

  // Client 1
  input  logic                 i_c1_req,
  input  uram_cfg_pkg::wmask_t i_c1_wmask,
  input  uram_cfg_pkg::addr_t  i_c1_addr,
  input  uram_cfg_pkg::data_t  i_c1_wdata,
  output logic                 o_c1_gnt,
  output logic                 o_c1_rvalid,
  output uram_cfg_pkg::data_t  o_c1_rdata,

  // Port A side
  output logic                 o_en,
  output uram_cfg_pkg::wmask_t o_wmask,
  output uram_cfg_pkg::addr_t  o_addr,
  output uram_cfg_pkg::data_t  o_wdata,
  input  logic                 i_rvalid,
  input  uram_cfg_pkg::data_t  i_rdata
);

  logic                req0;
  logic                req1;
  logic                rd_gnt;                          // Granted access is a read
  uram_arb_pkg::cid_t  last_win;
  uram_arb_pkg::cid_t  win;
  uram_arb_pkg::cid_t  tag_sr [uram_cfg_pkg::RD_LAT];   // Owner of each read in flight
  logic                rv     [uram_arb_pkg::NUM_CLIENTS];
  uram_cfg_pkg::data_t hold   [uram_arb_pkg::NUM_CLIENTS];
  uram_cfg_pkg::data_t rdata  [uram_arb_pkg::NUM_CLIENTS];

  // Nothing granted while the sweep runs
  assign req0 = i_c0_req & i_clear_done;
  assign req1 = i_c1_req & i_clear_done;

  // On a tie the loser of the last grant goes first
  assign o_c0_gnt = req0 & (~req1 | (last_win == uram_arb_pkg::CID_C1));
  assign o_c1_gnt = req1 & (~req0 | (last_win == uram_arb_pkg::CID_C0));
  assign win      = o_c1_gnt ? uram_arb_pkg::CID_C1 : uram_arb_pkg::CID_C0;

  // Winner onto port A
  assign o_en    = o_c0_gnt | o_c1_gnt;
  assign o_wmask = o_c1_gnt ? i_c1_wmask : i_c0_wmask;
  assign o_addr  = o_c1_gnt ? i_c1_addr  : i_c0_addr;
  assign o_wdata = o_c1_gnt ? i_c1_wdata : i_c0_wdata;
  assign rd_gnt  = o_en & ~|o_wmask;

  always_ff @(posedge clk)
  begin
    if (rsta)
      last_win <= uram_arb_pkg::CID_RST_LAST;
    else if (o_en)
      last_win <= win;
  end

  // Id travels beside the memory pipeline, tail meets i_rvalid
  always_ff @(posedge clk)
  begin
    if (rd_gnt)
      tag_sr[0] <= win;
    for (int s = 1; s < uram_cfg_pkg::RD_LAT; s++)
      tag_sr[s] <= tag_sr[s-1];
  end

  // Return routing, each client keeps its last word
  for (genvar c = 0; c < uram_arb_pkg::NUM_CLIENTS; c++)
  begin : g_ret
    assign rv[c] = i_rvalid &
                   (tag_sr[uram_cfg_pkg::RD_LAT-1] == uram_arb_pkg::cid_t'(c));

    always_ff @(posedge clk)
    begin
      if (rsta)
        hold[c] <= '0;
      else if (rv[c])
        hold[c] <= i_rdata;
    end

    assign rdata[c] = rv[c] ? i_rdata : hold[c];  // New word shows with its valid
  end

  assign o_c0_rvalid = rv[0];
  assign o_c0_rdata  = rdata[0];
  assign o_c1_rvalid = rv[1];
  assign o_c1_rdata  = rdata[1];

endmodule

// File: uram_shared_top.sv
//################################################
// Shared table: two clients on port A via
// round robin, port B direct
// Client grants wait for o_clear_done
//################################################
`timescale 1ns/100ps

module uram_shared_top (
  input  logic                 clk,
  input  logic                 rsta,

  // Client 0
  input  logic                 i_c0_req,
  input  uram_cfg_pkg::wmask_t i_c0_wmask,
  input  uram_cfg_pkg::addr_t  i_c0_addr,
  input  uram_cfg_pkg::data_t  i_c0_wdata,
  output logic                 o_c0_gnt,
  output logic                 o_c0_rvalid,
  output uram_cfg_pkg::data_t  o_c0_rdata,

  // Client 1
  input  logic                 i_c1_req,
  input  uram_cfg_pkg::wmask_t i_c1_wmask,
  input  uram_cfg_pkg::addr_t  i_c1_addr,
  input  uram_cfg_pkg::data_t  i_c1_wdata,
  output logic                 o_c1_gnt,
  output logic                 o_c1_rvalid,
  output uram_cfg_pkg::data_t  o_c1_rdata,

  // Port B
  input  logic                 i_b_en,
  input  uram_cfg_pkg::wmask_t i_b_wmask,
  input  uram_cfg_pkg::addr_t  i_b_addr,
  input  uram_cfg_pkg::data_t  i_b_wdata,
  output logic                 o_b_rvalid,
  output uram_cfg_pkg::data_t  o_b_rdata,

  output logic                 o_clear_done
);

  // Arbiter to sequencer
  logic                 arb_en;
  uram_cfg_pkg::wmask_t arb_wmask;
  uram_cfg_pkg::addr_t  arb_addr;
  uram_cfg_pkg::data_t  arb_wdata;

  // Sequencer to memory port A
  logic                 a_en;
  uram_cfg_pkg::wmask_t a_wmask;
  uram_cfg_pkg::addr_t  a_addr;
  uram_cfg_pkg::data_t  a_wdata;

  // Memory port A back to arbiter
  logic                 a_rvalid;
  uram_cfg_pkg::data_t  a_rdata;

  uram_port_arb u_arb (
    .clk          (clk),
    .rsta         (rsta),
    .i_clear_done (o_clear_done),
    .i_c0_req     (i_c0_req),
    .i_c0_wmask   (i_c0_wmask),
    .i_c0_addr    (i_c0_addr),
    .i_c0_wdata   (i_c0_wdata),
    .o_c0_gnt     (o_c0_gnt),
    .o_c0_rvalid  (o_c0_rvalid),
    .o_c0_rdata   (o_c0_rdata),
    .i_c1_req     (i_c1_req),
    .i_c1_wmask   (i_c1_wmask),
    .i_c1_addr    (i_c1_addr),
    .i_c1_wdata   (i_c1_wdata),
    .o_c1_gnt     (o_c1_gnt),
    .o_c1_rvalid  (o_c1_rvalid),
    .o_c1_rdata   (o_c1_rdata),
    .o_en         (arb_en),
    .o_wmask      (arb_wmask),
    .o_addr       (arb_addr),
    .o_wdata      (arb_wdata),
    .i_rvalid     (a_rvalid),
    .i_rdata      (a_rdata)
  );

  uram_clear_seq u_clear (
    .clk          (clk),
    .rsta         (rsta),
    .i_en         (arb_en),
    .i_wmask      (arb_wmask),
    .i_addr       (arb_addr),
    .i_wdata      (arb_wdata),
    .o_en         (a_en),
    .o_wmask      (a_wmask),
    .o_addr       (a_addr),
    .o_wdata      (a_wdata),
    .o_clear_done (o_clear_done)
  );

  uram_tdp_bytewrite u_mem (
    .clk          (clk),
    .rsta         (rsta),
    .i_a_en       (a_en),
    .i_a_wmask    (a_wmask),
    .i_a_addr     (a_addr),
    .i_a_wdata    (a_wdata),
    .i_b_en       (i_b_en),
    .i_b_wmask    (i_b_wmask),
    .i_b_addr     (i_b_addr),
    .i_b_wdata    (i_b_wdata),
    .o_a_rdata    (a_rdata),
    .o_a_rvalid   (a_rvalid),
    .o_b_rdata    (o_b_rdata),
    .o_b_rvalid   (o_b_rvalid)
  );

endmodule

// File: tb_uram_shared.sv
//################################################
// Table-driven testbench for the shared table top
// Reference model starts all zero like the sweep
// Port B never writes beside a client in one cycle
//################################################
`timescale 1ns/100ps

module tb_uram_shared;

  localparam int CLK_HALF   = 50;
  localparam int DRV_DLY    = 10;   // Inputs move after the edge
  localparam int RST_CYCLES = 16;
  localparam int MAX_ENT    = 64;
  localparam int P_C0       = 0;
  localparam int P_C1       = 1;
  localparam int P_B        = 2;

  logic clk;
  logic rsta;
  logic c0_req, c0_gnt, c0_rvalid;
  logic c1_req, c1_gnt, c1_rvalid;
  logic b_en, b_rvalid, clear_done;
  uram_cfg_pkg::wmask_t c0_wmask, c1_wmask, b_wmask;
  uram_cfg_pkg::addr_t  c0_addr, c1_addr, b_addr;
  uram_cfg_pkg::data_t  c0_wdata, c1_wdata, b_wdata;
  uram_cfg_pkg::data_t  c0_rdata, c1_rdata, b_rdata;

  // Stimulus table
  int                   tbl_port [MAX_ENT];
  uram_cfg_pkg::addr_t  tbl_addr [MAX_ENT];
  uram_cfg_pkg::wmask_t tbl_mask [MAX_ENT];  // Zero for a read
  uram_cfg_pkg::data_t  tbl_data [MAX_ENT];
  bit                   tbl_pair [MAX_ENT];  // Next entry goes in the same cycle
  int                   n_ent = 0;

  // Reference state
  uram_cfg_pkg::data_t ref_mem [uram_cfg_pkg::DEPTH];
  int                  exp_due [3][$];       // Cycle each read must return
  uram_cfg_pkg::data_t exp_dat [3][$];
  uram_cfg_pkg::data_t last_rd [3];          // Output holds this between reads
  logic [2:0]          pend;                 // Port still waiting, c0 c1 B
  logic                last_c1 = 1'b1;       // Last grant went to client 1
  int                  cyc = 0;
  int                  rel_edges = 0;        // Edges since reset released
  int                  limit = 0;

  always #CLK_HALF clk = ~clk;

  uram_shared_top i_dut (
    .clk (clk), .rsta (rsta),
    .i_c0_req (c0_req), .i_c0_wmask (c0_wmask), .i_c0_addr (c0_addr),
    .i_c0_wdata (c0_wdata), .o_c0_gnt (c0_gnt), .o_c0_rvalid (c0_rvalid),
    .o_c0_rdata (c0_rdata),
    .i_c1_req (c1_req), .i_c1_wmask (c1_wmask), .i_c1_addr (c1_addr),
    .i_c1_wdata (c1_wdata), .o_c1_gnt (c1_gnt), .o_c1_rvalid (c1_rvalid),
    .o_c1_rdata (c1_rdata),
    .i_b_en (b_en), .i_b_wmask (b_wmask), .i_b_addr (b_addr), .i_b_wdata (b_wdata),
    .o_b_rvalid (b_rvalid), .o_b_rdata (b_rdata),
    .o_clear_done (clear_done)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_data(input string name, input uram_cfg_pkg::data_t got,
                            input uram_cfg_pkg::data_t exp);
    if (got !== exp)
      fail_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // Random mask and data for writes
  task automatic add_entry(input int port, input bit wr, input int addr, input bit pair);
    tbl_port[n_ent] = port;
    tbl_addr[n_ent] = uram_cfg_pkg::addr_t'(addr);
    tbl_mask[n_ent] = wr ? uram_cfg_pkg::wmask_t'($urandom_range(511, 1)) : '0;
    tbl_data[n_ent] = uram_cfg_pkg::data_t'({$urandom(), $urandom(), $urandom()});
    tbl_pair[n_ent] = pair;
    n_ent++;
  endtask

  task automatic ref_write(input uram_cfg_pkg::addr_t a, input uram_cfg_pkg::wmask_t m,
                           input uram_cfg_pkg::data_t d);
    for (int c = 0; c < uram_cfg_pkg::NUM_COL; c++)
    begin
      if (m[c])
        ref_mem[a][c*uram_cfg_pkg::COL_W +: uram_cfg_pkg::COL_W] =
          d[c*uram_cfg_pkg::COL_W +: uram_cfg_pkg::COL_W];
    end
  endtask

  task automatic expect_read(input int p, input uram_cfg_pkg::addr_t a);
    exp_due[p].push_back(cyc + uram_cfg_pkg::RD_LAT);
    exp_dat[p].push_back(ref_mem[a]);
  endtask

  // Valid on the due cycle only, data held otherwise
  task automatic check_return(input int p, input string name, input logic rv,
                              input uram_cfg_pkg::data_t rd);
    logic v_exp;
    v_exp = (exp_due[p].size() > 0) && (exp_due[p][0] == cyc);
    check_bit({name, "_rvalid"}, rv, v_exp);
    if (v_exp)
    begin
      last_rd[p] = exp_dat[p].pop_front();
      void'(exp_due[p].pop_front());
    end
    check_data({name, "_rdata"}, rd, last_rd[p]);
  endtask

  // Sampled mid-cycle, all outputs settled
  task automatic check_cycle();
    logic done_exp;
    logic g0;
    logic g1;
    done_exp = (rel_edges >= uram_cfg_pkg::CLEAR_CYCLES + 1);
    check_bit("o_clear_done", clear_done, done_exp);
    g0 = done_exp & c0_req & (~c1_req | last_c1);     // Loser of last round first
    g1 = done_exp & c1_req & (~c0_req | ~last_c1);
    check_bit("o_c0_gnt", c0_gnt, g0);
    check_bit("o_c1_gnt", c1_gnt, g1);
    check_return(P_C0, "o_c0", c0_rvalid, c0_rdata);
    check_return(P_C1, "o_c1", c1_rvalid, c1_rdata);
    check_return(P_B, "o_b", b_rvalid, b_rdata);
    // Reads see the array before this cycle's writes
    if (g0 && c0_wmask == '0)
      expect_read(P_C0, c0_addr);
    if (g1 && c1_wmask == '0)
      expect_read(P_C1, c1_addr);
    if (b_en && b_wmask == '0)
      expect_read(P_B, b_addr);
    if (g0)
      ref_write(c0_addr, c0_wmask, c0_wdata);  // Zero mask writes nothing
    if (g1)
      ref_write(c1_addr, c1_wmask, c1_wdata);
    if (b_en)
      ref_write(b_addr, b_wmask, b_wdata);
    if (g0 | g1)
      last_c1 = g1;
    if (g0)
      pend[P_C0] = 1'b0;
    if (g1)
      pend[P_C1] = 1'b0;
    pend[P_B] = 1'b0;                          // Port B takes one cycle
  endtask

  task automatic load_entry(input int i);
    case (tbl_port[i])
      P_C0:
      begin
        c0_wmask = tbl_mask[i];
        c0_addr  = tbl_addr[i];
        c0_wdata = tbl_data[i];
      end
      P_C1:
      begin
        c1_wmask = tbl_mask[i];
        c1_addr  = tbl_addr[i];
        c1_wdata = tbl_data[i];
      end
      default:
      begin
        b_wmask = tbl_mask[i];
        b_addr  = tbl_addr[i];
        b_wdata = tbl_data[i];
      end
    endcase
    pend[tbl_port[i]] = 1'b1;
  endtask

  task automatic run_cycle(input int first, input int cnt);
    @(posedge clk);
    #DRV_DLY;
    rsta = (cyc < RST_CYCLES);
    for (int i = first; i < first + cnt; i++)
      load_entry(i);
    c0_req = pend[P_C0];                       // Held until granted
    c1_req = pend[P_C1];
    b_en   = pend[P_B];
    #(CLK_HALF - DRV_DLY);
    check_cycle();
  endtask

  // Cycle count and watchdog
  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (!rsta)
      rel_edges <= rel_edges + 1;
    if (limit > 0 && cyc > limit)
      fail_run($sformatf("Timeout, run still busy after %0d cycles", limit));
  end

  initial
  begin
    int idx;
    int nsel;
    void'($urandom(35513));
    clk = 1'b0;
    rsta = 1'b1;
    {c0_req, c1_req, b_en} = '0;
    {c0_wmask, c1_wmask, b_wmask} = '0;
    {c0_wdata, c1_wdata, b_wdata} = '0;
    c0_addr = 12'h123;                         // Held read through the sweep
    c1_addr = '0;
    b_addr  = '0;
    pend    = 3'b001;
    for (int a = 0; a < uram_cfg_pkg::DEPTH; a++)
      ref_mem[a] = '0;
    for (int p = 0; p < 3; p++)
      last_rd[p] = '0;
    // Cleared words read back zero
    add_entry(P_C1, 0, 'habc, 0);
    add_entry(P_B,  0, 'h777, 0);
    add_entry(P_C0, 0, 'hfff, 0);
    // Byte-masked writes, merged word seen on port B
    add_entry(P_C0, 1, 'h040, 0);
    add_entry(P_C0, 1, 'h040, 0);
    add_entry(P_C0, 1, 'h041, 0);
    add_entry(P_B,  0, 'h040, 0);
    add_entry(P_B,  0, 'h041, 0);
    // Both clients at once
    add_entry(P_C0, 0, 'h040, 1);
    add_entry(P_C1, 0, 'h041, 0);
    add_entry(P_C1, 0, 'h041, 0);              // Lone client 1 grant, next tie goes to client 0
    add_entry(P_C0, 0, 'h041, 1);
    add_entry(P_C1, 0, 'h040, 0);
    add_entry(P_C0, 1, 'h050, 1);
    add_entry(P_C1, 1, 'h051, 0);
    add_entry(P_C0, 0, 'h050, 1);
    add_entry(P_C1, 0, 'h051, 0);
    // Back to back, several in flight
    add_entry(P_C0, 0, 'h040, 0);
    add_entry(P_C0, 0, 'h041, 0);
    add_entry(P_C0, 0, 'h050, 0);
    add_entry(P_C0, 0, 'h051, 0);
    add_entry(P_C1, 0, 'h050, 0);
    add_entry(P_B,  0, 'h051, 0);
    // Port B writes keep rdata, client 1 reads them
    add_entry(P_B,  0, 'h040, 0);
    add_entry(P_B,  1, 'h060, 0);
    add_entry(P_B,  1, 'h041, 0);
    add_entry(P_C1, 0, 'h060, 0);
    add_entry(P_C1, 0, 'h041, 0);
    limit = uram_cfg_pkg::CLEAR_CYCLES + RST_CYCLES + 8 * n_ent;

    while (pend != '0)                         // Reset, sweep, first grant
      run_cycle(0, 0);
    idx = 0;
    while (idx < n_ent)
    begin
      nsel = (tbl_pair[idx] && idx + 1 < n_ent) ? 2 : 1;
      run_cycle(idx, nsel);
      while (pend != '0)
        run_cycle(0, 0);
      idx += nsel;
    end
    while (exp_due[0].size() + exp_due[1].size() + exp_due[2].size() > 0)
      run_cycle(0, 0);
    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: vlog.f
uram_cfg_pkg.sv
uram_arb_pkg.sv
uram_tdp_bytewrite.sv
uram_clear_seq.sv
uram_port_arb.sv
uram_shared_top.sv
tb_uram_shared.sv

// File: Bender.yml
package:
  name: uram_shared

sources:
  # Packages first, then RTL bottom up
  - uram_cfg_pkg.sv
  - uram_arb_pkg.sv
  - uram_tdp_bytewrite.sv
  - uram_clear_seq.sv
  - uram_port_arb.sv
  - uram_shared_top.sv
  - target: test
    files:
      - tb_uram_shared.sv
